// ==== source/lms_sample_pkg.sv ====
/* LMS6002D sample definitions
   Bus and ADC widths plus the word and sample types shared by the datapaths */

`default_nettype none

package lms_sample_pkg;

   // Parallel data bus of one LMS chip
   localparam int LMS_DATA_W = 12;

   // Sample width used inside the radio core
   localparam int ADC_W = 14;

   // Zero bits appended below a received word to left-align it
   localparam int ADC_PAD_W = ADC_W - LMS_DATA_W;

   // One word as seen on the chip bus, RX or TX
   typedef logic [LMS_DATA_W-1:0] lms_word_t;

   // One aligned I or Q sample after capture
   typedef logic [ADC_W-1:0] adc_sample_t;

endpackage

`default_nettype wire

// ==== source/lms_ctrl_pkg.sv ====
/* LMS front end control definitions
   SPI target count, chip select indices and the select vector type */

`default_nettype none

package lms_ctrl_pkg;

   // Targets on the shared SPI bus
   localparam int SPI_TARGETS = 3;

   // Select index per target
   // The clock DAC sits lowest since it has no MISO pin
   localparam int SPI_DAC  = 0;
   localparam int SPI_LMS1 = 1;   // First transceiver
   localparam int SPI_LMS2 = 2;   // Second transceiver

   // Active-low chip selects, one bit per target
   typedef logic [SPI_TARGETS-1:0] sen_vec_t;

endpackage

`default_nettype wire

// ==== source/lms_rx_capture.sv ====
/* LMS receive capture
   Splits one chip's interleaved RX bus into left-aligned I and Q samples */

`default_nettype none

module lms_rx_capture #(
   parameter int PAD_W = lms_sample_pkg::ADC_PAD_W
) (
   input  wire                          lms_clk,
   input  wire                          rst_n_i,
   input  wire                          iqsel_i,   // High for I, low for Q
   input  wire lms_sample_pkg::lms_word_t   data_i,
   output lms_sample_pkg::adc_sample_t  i_o,
   output lms_sample_pkg::adc_sample_t  q_o,
   output logic                         valid_o
);

   lms_sample_pkg::adc_sample_t aligned_w;
   lms_sample_pkg::adc_sample_t i_r;
   lms_sample_pkg::adc_sample_t q_r;
   logic                        valid_r;

   // Chip word goes to the top of the ADC sample
   assign aligned_w = {data_i, {PAD_W{1'b0}}};

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         i_r     <= '0;
         q_r     <= '0;
         valid_r <= 1'b0;
      end
      else
      begin
         // A Q word closes the pair, so flag it with the Q load
         valid_r <= ~iqsel_i;
         if (iqsel_i)
         begin
            i_r <= aligned_w;   // I half
         end
         else
         begin
            q_r <= aligned_w;   // Q half
         end
      end
   end

   // No back-pressure, next pair simply overwrites
   assign i_o     = i_r;
   assign q_o     = q_r;
   assign valid_o = valid_r;

endmodule

`default_nettype wire

// ==== source/lms_tx_interleave.sv ====
/* LMS transmit interleaver
   Puts one chip's I and Q words on its shared TX bus on alternate cycles */

`default_nettype none

module lms_tx_interleave (
   input  wire                           lms_clk,
   input  wire                           rst_n_i,
   input  wire lms_sample_pkg::lms_word_t    tx_i_i,
   input  wire lms_sample_pkg::lms_word_t    tx_q_i,
   output lms_sample_pkg::lms_word_t     data_o,
   output logic                          iqsel_o   // Low with I, high with Q
);

   // Which half of the pair goes out at the coming edge
   typedef enum logic {
      PH_Q = 1'b0,
      PH_I = 1'b1
   } tx_phase_t;

   tx_phase_t                  phase_r;
   tx_phase_t                  phase_nxt;
   lms_sample_pkg::lms_word_t  data_r;
   logic                       iqsel_r;

   // Phase flips on every clock
   assign phase_nxt = (phase_r == PH_I) ? PH_Q : PH_I;

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         phase_r <= PH_Q;    // First word out of reset is I
         data_r  <= '0;
         iqsel_r <= 1'b1;
      end
      else
      begin
         phase_r <= phase_nxt;
         if (phase_nxt == PH_I)
         begin
            data_r  <= tx_i_i;
            iqsel_r <= 1'b0;
         end
         else
         begin
            data_r  <= tx_q_i;
            iqsel_r <= 1'b1;
         end
      end
   end

   assign data_o  = data_r;
   assign iqsel_o = iqsel_r;

endmodule

`default_nettype wire

// ==== source/lms_spi_fanout.sv ====
/* SPI fan-out
   Gates the master clock and data per target and merges target MISO lines */

`default_nettype none

module lms_spi_fanout #(
   parameter int NUM_MISO = 2
) (
   input  wire                               sclk_i,
   input  wire                               mosi_i,
   input  wire lms_ctrl_pkg::sen_vec_t       sen_i,    // Active low
   output logic [lms_ctrl_pkg::SPI_TARGETS-1:0] sclk_o,
   output logic [lms_ctrl_pkg::SPI_TARGETS-1:0] mosi_o,
   input  wire  [NUM_MISO-1:0]               miso_i,
   output logic                              miso_o
);

   // MISO capable targets take the upper select indices
   localparam int MISO_BASE = lms_ctrl_pkg::SPI_TARGETS - NUM_MISO;

   logic miso_acc;

   // Idle targets see a quiet bus
   for (genvar t = 0; t < lms_ctrl_pkg::SPI_TARGETS; t++)
   begin : g_target
      assign sclk_o[t] = ~sen_i[t] & sclk_i;
      assign mosi_o[t] = ~sen_i[t] & mosi_i;
   end

   always_comb
   begin
      miso_acc = 1'b0;
      for (int k = 0; k < NUM_MISO; k++)
      begin
         // Only a selected target may drive the return line
         miso_acc = miso_acc | (miso_i[k] & ~sen_i[MISO_BASE+k]);
      end
   end

   assign miso_o = miso_acc;

endmodule

`default_nettype wire

// ==== source/umtrx_lms_frontend.sv ====
/* UmTRX LMS6002D front end
   Two RX captures, two TX interleavers and the SPI fan-out side by side */

`default_nettype none

module umtrx_lms_frontend #(
   parameter int PAD_W    = lms_sample_pkg::ADC_PAD_W,
   parameter int NUM_MISO = 2   // Both LMS chips, DAC is write only
) (
   input  wire                                  lms_clk,
   input  wire                                  rst_n_i,

   // LMS 1 receive
   input  wire                                  rx_iqsel_1_i,
   input  wire lms_sample_pkg::lms_word_t       rx_data_1_i,
   output lms_sample_pkg::adc_sample_t          rx_i_1_o,
   output lms_sample_pkg::adc_sample_t          rx_q_1_o,
   output logic                                 rx_valid_1_o,

   // LMS 2 receive
   input  wire                                  rx_iqsel_2_i,
   input  wire lms_sample_pkg::lms_word_t       rx_data_2_i,
   output lms_sample_pkg::adc_sample_t          rx_i_2_o,
   output lms_sample_pkg::adc_sample_t          rx_q_2_o,
   output logic                                 rx_valid_2_o,

   // Transmit, user words held as levels
   input  wire lms_sample_pkg::lms_word_t       tx_i_1_i,
   input  wire lms_sample_pkg::lms_word_t       tx_q_1_i,
   output lms_sample_pkg::lms_word_t            tx_data_1_o,
   output logic                                 tx_iqsel_1_o,
   input  wire lms_sample_pkg::lms_word_t       tx_i_2_i,
   input  wire lms_sample_pkg::lms_word_t       tx_q_2_i,
   output lms_sample_pkg::lms_word_t            tx_data_2_o,
   output logic                                 tx_iqsel_2_o,

   // SPI master side
   input  wire                                  spi_sclk_i,
   input  wire                                  spi_mosi_i,
   input  wire lms_ctrl_pkg::sen_vec_t          spi_sen_i,
   output logic                                 spi_miso_o,

   // SPI target side
   output logic [lms_ctrl_pkg::SPI_TARGETS-1:0] spi_sclk_o,
   output logic [lms_ctrl_pkg::SPI_TARGETS-1:0] spi_mosi_o,
   output lms_ctrl_pkg::sen_vec_t               spi_sen_o,
   input  wire  [NUM_MISO-1:0]                  spi_miso_i
);

   lms_rx_capture #(.PAD_W(PAD_W)) u_rx_1 (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .iqsel_i (rx_iqsel_1_i),
      .data_i  (rx_data_1_i),
      .i_o     (rx_i_1_o),
      .q_o     (rx_q_1_o),
      .valid_o (rx_valid_1_o)
   );

   lms_rx_capture #(.PAD_W(PAD_W)) u_rx_2 (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .iqsel_i (rx_iqsel_2_i),
      .data_i  (rx_data_2_i),
      .i_o     (rx_i_2_o),
      .q_o     (rx_q_2_o),
      .valid_o (rx_valid_2_o)
   );

   lms_tx_interleave u_tx_1 (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .tx_i_i  (tx_i_1_i),
      .tx_q_i  (tx_q_1_i),
      .data_o  (tx_data_1_o),
      .iqsel_o (tx_iqsel_1_o)
   );

   lms_tx_interleave u_tx_2 (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .tx_i_i  (tx_i_2_i),
      .tx_q_i  (tx_q_2_i),
      .data_o  (tx_data_2_o),
      .iqsel_o (tx_iqsel_2_o)
   );

   lms_spi_fanout #(.NUM_MISO(NUM_MISO)) u_spi (
      .sclk_i  (spi_sclk_i),
      .mosi_i  (spi_mosi_i),
      .sen_i   (spi_sen_i),
      .sclk_o  (spi_sclk_o),
      .mosi_o  (spi_mosi_o),
      .miso_i  (spi_miso_i),
      .miso_o  (spi_miso_o)
   );

   assign spi_sen_o = spi_sen_i;   // Selects go straight to the pins

endmodule

`default_nettype wire

// ==== dv/umtrx_lms_frontend_checker.sv ====
/* Front end port checker
   Bound assertions for TX alternation, SPI gating and reset state */

`default_nettype none

module umtrx_lms_frontend_checker (
   input wire                                  lms_clk,
   input wire                                  rst_n_i,
   input wire lms_sample_pkg::adc_sample_t     rx_i_1_o,
   input wire lms_sample_pkg::adc_sample_t     rx_q_1_o,
   input wire                                  rx_valid_1_o,
   input wire lms_sample_pkg::adc_sample_t     rx_i_2_o,
   input wire lms_sample_pkg::adc_sample_t     rx_q_2_o,
   input wire                                  rx_valid_2_o,
   input wire lms_sample_pkg::lms_word_t       tx_i_1_i,
   input wire lms_sample_pkg::lms_word_t       tx_q_1_i,
   input wire lms_sample_pkg::lms_word_t       tx_data_1_o,
   input wire                                  tx_iqsel_1_o,
   input wire lms_sample_pkg::lms_word_t       tx_i_2_i,
   input wire lms_sample_pkg::lms_word_t       tx_q_2_i,
   input wire lms_sample_pkg::lms_word_t       tx_data_2_o,
   input wire                                  tx_iqsel_2_o,
   input wire                                  spi_sclk_i,
   input wire                                  spi_mosi_i,
   input wire lms_ctrl_pkg::sen_vec_t          spi_sen_i,
   input wire [lms_ctrl_pkg::SPI_TARGETS-1:0]  spi_sclk_o,
   input wire [lms_ctrl_pkg::SPI_TARGETS-1:0]  spi_mosi_o,
   input wire lms_ctrl_pkg::sen_vec_t          spi_sen_o
);

   localparam int NT = lms_ctrl_pkg::SPI_TARGETS;

   int   fail_count = 0;
   logic past_valid = 1'b0;   // Guards $past on the first edge

   always_ff @(posedge lms_clk)
   begin
      past_valid <= 1'b1;
   end

   // Select flips every cycle once the interleavers run
   a_tx_toggle: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      (past_valid && $past(rst_n_i)) |->
         (tx_iqsel_1_o != $past(tx_iqsel_1_o)) && (tx_iqsel_2_o != $past(tx_iqsel_2_o)))
      else begin fail_count = fail_count + 1; $error("TX select did not toggle"); end

   a_tx_data_1: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      (past_valid && $past(rst_n_i)) |->
         tx_data_1_o == (tx_iqsel_1_o ? $past(tx_q_1_i) : $past(tx_i_1_i)))
      else begin fail_count = fail_count + 1; $error("TX 1 word mismatch"); end

   a_tx_data_2: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      (past_valid && $past(rst_n_i)) |->
         tx_data_2_o == (tx_iqsel_2_o ? $past(tx_q_2_i) : $past(tx_i_2_i)))
      else begin fail_count = fail_count + 1; $error("TX 2 word mismatch"); end

   // Combinational router, checked at every edge
   a_spi_gate: assert property (@(posedge lms_clk)
      (spi_sclk_o == (~spi_sen_i & {NT{spi_sclk_i}})) &&
      (spi_mosi_o == (~spi_sen_i & {NT{spi_mosi_i}})) &&
      (spi_sen_o == spi_sen_i))
      else begin fail_count = fail_count + 1; $error("SPI gating mismatch"); end

   a_reset_state: assert property (@(posedge lms_clk)
      (past_valid && !rst_n_i) |->
         !rx_valid_1_o && !rx_valid_2_o &&
         rx_i_1_o == '0 && rx_q_1_o == '0 && rx_i_2_o == '0 && rx_q_2_o == '0 &&
         tx_data_1_o == '0 && tx_data_2_o == '0 && tx_iqsel_1_o && tx_iqsel_2_o)
      else begin fail_count = fail_count + 1; $error("Outputs not in reset state"); end

   // I goes out first after release
   a_first_word: assert property (@(posedge lms_clk)
      (past_valid && rst_n_i && !$past(rst_n_i)) |=> (!tx_iqsel_1_o && !tx_iqsel_2_o))
      else begin fail_count = fail_count + 1; $error("First TX word was not I"); end

endmodule

bind umtrx_lms_frontend umtrx_lms_frontend_checker chk (.*);

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
/* Testbench clock source
   Free-running lms_clk for the front end testbench */

`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD = 8
) (
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
   end

   always #(PERIOD / 2) clk_o = ~clk_o;   // Half period per phase

endmodule

`default_nettype wire

// ==== dv/tb_umtrx_lms_frontend.sv ====
/* Front end testbench
   Random RX, TX and SPI stimulus with a reference model for RX pairs and MISO */

`default_nettype none

module tb_umtrx_lms_frontend;

   localparam int PAD        = lms_sample_pkg::ADC_PAD_W;
   localparam int MAX_CYCLES = 2000;   // Four phases near 300 cycles plus margin

   logic                        lms_clk;
   logic                        rst_n_i;
   logic                        rx_iqsel_1_i;
   lms_sample_pkg::lms_word_t   rx_data_1_i;
   lms_sample_pkg::adc_sample_t rx_i_1_o;
   lms_sample_pkg::adc_sample_t rx_q_1_o;
   logic                        rx_valid_1_o;
   logic                        rx_iqsel_2_i;
   lms_sample_pkg::lms_word_t   rx_data_2_i;
   lms_sample_pkg::adc_sample_t rx_i_2_o;
   lms_sample_pkg::adc_sample_t rx_q_2_o;
   logic                        rx_valid_2_o;
   lms_sample_pkg::lms_word_t   tx_i_1_i;
   lms_sample_pkg::lms_word_t   tx_q_1_i;
   lms_sample_pkg::lms_word_t   tx_data_1_o;
   logic                        tx_iqsel_1_o;
   lms_sample_pkg::lms_word_t   tx_i_2_i;
   lms_sample_pkg::lms_word_t   tx_q_2_i;
   lms_sample_pkg::lms_word_t   tx_data_2_o;
   logic                        tx_iqsel_2_o;
   logic                        spi_sclk_i;
   logic                        spi_mosi_i;
   lms_ctrl_pkg::sen_vec_t      spi_sen_i;
   logic                        spi_miso_o;
   logic [2:0]                  spi_sclk_o;
   logic [2:0]                  spi_mosi_o;
   lms_ctrl_pkg::sen_vec_t      spi_sen_o;
   logic [1:0]                  spi_miso_i;

   // Reference model state
   lms_sample_pkg::adc_sample_t exp_i_1;
   lms_sample_pkg::adc_sample_t exp_q_1;
   lms_sample_pkg::adc_sample_t exp_i_2;
   lms_sample_pkg::adc_sample_t exp_q_2;
   logic                        exp_valid_1;
   logic                        exp_valid_2;

   logic [31:0] lcg_state = 32'hf197;
   int          cycle_count = 0;

   tb_clock_gen #(.PERIOD(8)) u_clk (.clk_o(lms_clk));

   umtrx_lms_frontend #(.PAD_W(PAD), .NUM_MISO(2)) dut (
      .lms_clk      (lms_clk),      .rst_n_i      (rst_n_i),
      .rx_iqsel_1_i (rx_iqsel_1_i), .rx_data_1_i  (rx_data_1_i),
      .rx_i_1_o     (rx_i_1_o),     .rx_q_1_o     (rx_q_1_o),
      .rx_valid_1_o (rx_valid_1_o),
      .rx_iqsel_2_i (rx_iqsel_2_i), .rx_data_2_i  (rx_data_2_i),
      .rx_i_2_o     (rx_i_2_o),     .rx_q_2_o     (rx_q_2_o),
      .rx_valid_2_o (rx_valid_2_o),
      .tx_i_1_i     (tx_i_1_i),     .tx_q_1_i     (tx_q_1_i),
      .tx_data_1_o  (tx_data_1_o),  .tx_iqsel_1_o (tx_iqsel_1_o),
      .tx_i_2_i     (tx_i_2_i),     .tx_q_2_i     (tx_q_2_i),
      .tx_data_2_o  (tx_data_2_o),  .tx_iqsel_2_o (tx_iqsel_2_o),
      .spi_sclk_i   (spi_sclk_i),   .spi_mosi_i   (spi_mosi_i),
      .spi_sen_i    (spi_sen_i),    .spi_miso_o   (spi_miso_o),
      .spi_sclk_o   (spi_sclk_o),   .spi_mosi_o   (spi_mosi_o),
      .spi_sen_o    (spi_sen_o),    .spi_miso_i   (spi_miso_i)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic next_rand(output logic [31:0] v);
      lcg_state = lcg_next(lcg_state);
      v = lcg_state;
   endtask

   task automatic report_failure();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
      assert (act === exp)
      else
      begin
         $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
         report_failure();
      end
   endtask

   // One cycle of random stimulus
   // A chip with rx off keeps its select high
   task automatic drive_random(input bit rx1_on, input bit rx2_on, input int alt);
      logic [31:0] r;
      next_rand(r);
      rx_data_1_i  = r[31:20];
      rx_iqsel_1_i = !rx1_on ? 1'b1 : (alt >= 0 ? alt[0] : r[17]);
      next_rand(r);
      rx_data_2_i  = r[31:20];
      rx_iqsel_2_i = !rx2_on ? 1'b1 : (alt >= 0 ? ~alt[0] : r[16]);
      next_rand(r);
      tx_i_1_i = r[31:20];
      tx_q_1_i = r[19:8];
      next_rand(r);
      tx_i_2_i = r[31:20];
      tx_q_2_i = r[19:8];
      next_rand(r);
      spi_sen_i  = r[31:29];
      spi_sclk_i = r[28];
      spi_mosi_i = r[27];
      spi_miso_i = r[26:25];
   endtask

   // Expected RX pairs with each word shifted up to the ADC width
   always @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         exp_i_1     <= '0;
         exp_q_1     <= '0;
         exp_valid_1 <= 1'b0;
         exp_i_2     <= '0;
         exp_q_2     <= '0;
         exp_valid_2 <= 1'b0;
      end
      else
      begin
         if (rx_iqsel_1_i) exp_i_1 <= lms_sample_pkg::adc_sample_t'(rx_data_1_i) << PAD;
         else exp_q_1 <= lms_sample_pkg::adc_sample_t'(rx_data_1_i) << PAD;
         if (rx_iqsel_2_i) exp_i_2 <= lms_sample_pkg::adc_sample_t'(rx_data_2_i) << PAD;
         else exp_q_2 <= lms_sample_pkg::adc_sample_t'(rx_data_2_i) << PAD;
         exp_valid_1 <= !rx_iqsel_1_i;
         exp_valid_2 <= !rx_iqsel_2_i;
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge lms_clk)
   begin
      logic exp_miso;
      if (dut.chk.fail_count != 0)
      begin
         $display("A port assertion in the checker failed");
         report_failure();
      end
      exp_miso = (spi_miso_i[0] & !spi_sen_i[lms_ctrl_pkg::SPI_LMS1])
               | (spi_miso_i[1] & !spi_sen_i[lms_ctrl_pkg::SPI_LMS2]);
      check_value("spi_miso_o", spi_miso_o, exp_miso);
      if (rst_n_i)
      begin
         check_value("rx_valid_1_o", rx_valid_1_o, exp_valid_1);
         check_value("rx_valid_2_o", rx_valid_2_o, exp_valid_2);
         if (exp_valid_1)
         begin
            check_value("rx_i_1_o", rx_i_1_o, exp_i_1);
            check_value("rx_q_1_o", rx_q_1_o, exp_q_1);
         end
         if (exp_valid_2)
         begin
            check_value("rx_i_2_o", rx_i_2_o, exp_i_2);
            check_value("rx_q_2_o", rx_q_2_o, exp_q_2);
         end
      end
   end

   always @(posedge lms_clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles without reaching the end", cycle_count);
         report_failure();
      end
   end

   initial
   begin
      rst_n_i = 1'b0;
      rx_iqsel_1_i = 1'b1;
      rx_data_1_i = '0;
      rx_iqsel_2_i = 1'b1;
      rx_data_2_i = '0;
      tx_i_1_i = '0;
      tx_q_1_i = '0;
      tx_i_2_i = '0;
      tx_q_2_i = '0;
      spi_sclk_i = 1'b0;
      spi_mosi_i = 1'b0;
      spi_sen_i = '1;
      spi_miso_i = '0;
      // Random traffic while reset holds the outputs
      repeat (10)
      begin
         @(posedge lms_clk);
         #1 drive_random(1'b1, 1'b1, -1);
      end
      rst_n_i = 1'b1;
      // Chip 1 traffic only while chip 2 stays without pairs
      repeat (300)
      begin
         @(posedge lms_clk);
         #1 drive_random(1'b1, 1'b0, -1);
      end
      // Chip 2 traffic only
      repeat (300)
      begin
         @(posedge lms_clk);
         #1 drive_random(1'b0, 1'b1, -1);
      end
      // Both chips with back to back pairs
      for (int c = 0; c < 300; c++)
      begin
         @(posedge lms_clk);
         #1 drive_random(1'b1, 1'b1, (c < 150) ? c : -1);
      end
      // Every select pattern with every master and MISO level
      for (int p = 0; p < 128; p++)
      begin
         @(posedge lms_clk);
         #1 drive_random(1'b1, 1'b1, -1);
         spi_sen_i  = p[2:0];
         spi_sclk_i = p[3];
         spi_mosi_i = p[4];
         spi_miso_i = p[6:5];
      end
      repeat (4) @(posedge lms_clk);
      @(negedge lms_clk);
      if (dut.chk.fail_count == 0)
      begin
         $display("TEST OK");
         $finish;
      end
      else
      begin
         $display("A port assertion in the checker failed");
         report_failure();
      end
   end

endmodule

`default_nettype wire

// ==== umtrx_lms_frontend.f ====
source/lms_sample_pkg.sv
source/lms_ctrl_pkg.sv
source/lms_rx_capture.sv
source/lms_tx_interleave.sv
source/lms_spi_fanout.sv
source/umtrx_lms_frontend.sv
dv/umtrx_lms_frontend_checker.sv
dv/tb_clock_gen.sv
dv/tb_umtrx_lms_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_umtrx_lms_frontend
FILELIST  ?= umtrx_lms_frontend.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
